// File: hdl/ibuf_line_pkg.sv
`default_nettype none

package ibuf_line_pkg;

    // one instruction cache line as delivered by either bank
    localparam int LINE_BITS = 128;

    typedef logic [LINE_BITS-1:0] cache_line_t;

endpackage

`default_nettype wire

// File: hdl/ibuf_ctrl_pkg.sv
`default_nettype none

package ibuf_ctrl_pkg;

    localparam int NUM_SLOTS = 4;

    localparam logic [NUM_SLOTS-1:0] EVEN_MASK = 4'b0101; // slots 00 and 10
    localparam logic [NUM_SLOTS-1:0] ODD_MASK  = 4'b1010; // slots 01 and 11

    typedef logic [1:0] slot_idx_t;  // bit 0 set means odd slot
    typedef logic [3:0] line_off_t;  // byte offset inside a line
    typedef logic [5:0] bip_t;       // {slot, offset}

    // encoding order matters, bit 1 = even bank, bit 0 = odd bank
    typedef enum logic [1:0] {
        LD_NONE = 2'b00,
        LD_ODD  = 2'b01,
        LD_EVEN = 2'b10,
        LD_BOTH = 2'b11
    } ld_mode_t;

    function automatic slot_idx_t bip_slot(bip_t bip);
        return bip[5:4];
    endfunction

    function automatic line_off_t bip_off(bip_t bip);
        return bip[3:0];
    endfunction

    function automatic logic [NUM_SLOTS-1:0] slot_onehot(slot_idx_t idx);
        logic [NUM_SLOTS-1:0] oh;
        oh      = '0;
        oh[idx] = 1'b1;
        return oh;
    endfunction

endpackage

`default_nettype wire

// File: hdl/ibuf_fill_ctrl.sv
`default_nettype none

module ibuf_fill_ctrl
    import ibuf_ctrl_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset_i,
    input  logic                 cf_i,
    input  logic [NUM_SLOTS-1:0] valid_i,
    input  slot_idx_t            even_slot_i,
    input  slot_idx_t            odd_slot_i,
    input  logic                 miss_even_i,
    input  logic                 miss_odd_i,
    input  logic                 wait_even_i,
    input  logic                 wait_odd_i,
    output logic [NUM_SLOTS-1:0] ld_slot_o,
    output logic                 even_loaded_o,
    output logic                 odd_loaded_o
);

    ld_mode_t             mode_q;
    ld_mode_t             mode_nxt;
    ld_mode_t             mode_eff;
    logic [NUM_SLOTS-1:0] empty;
    logic [NUM_SLOTS-1:0] empty_nbr;
    logic                 pair_empty;
    logic                 even_empty;
    logic                 odd_empty;
    logic                 take_even;
    logic                 take_odd;
    logic [NUM_SLOTS-1:0] even_strb;
    logic [NUM_SLOTS-1:0] odd_strb;

    assign empty = ~valid_i;

    // neighbour of slot i is slot i+1 around the ring
    assign empty_nbr  = {empty[0], empty[3:1]};
    assign pair_empty = |(empty & empty_nbr);
    assign even_empty = |(empty & EVEN_MASK);
    assign odd_empty  = |(empty & ODD_MASK);

    always_comb begin
        if (pair_empty) begin
            mode_nxt = LD_BOTH;
        end else if (even_empty) begin
            mode_nxt = LD_EVEN;
        end else if (odd_empty) begin
            mode_nxt = LD_ODD;
        end else begin
            mode_nxt = LD_NONE;
        end
    end

    // a miss on either bank freezes the mode
    always_ff @(posedge clk) begin
        if (reset_i) begin
            mode_q <= LD_BOTH;
        end else if (!miss_even_i && !miss_odd_i) begin
            mode_q <= mode_nxt;
        end
    end

    assign mode_eff = cf_i ? LD_BOTH : mode_q; // refill both banks after a redirect

    assign take_even = ((mode_eff == LD_EVEN) || (mode_eff == LD_BOTH))
                       && !miss_even_i && !wait_even_i;
    assign take_odd  = ((mode_eff == LD_ODD) || (mode_eff == LD_BOTH))
                       && !miss_odd_i && !wait_odd_i;

    // a bank can only ever write slots of its own parity
    assign even_strb = take_even ? (slot_onehot(even_slot_i) & EVEN_MASK) : '0;
    assign odd_strb  = take_odd ? (slot_onehot(odd_slot_i) & ODD_MASK) : '0;

    assign ld_slot_o     = even_strb | odd_strb;
    assign even_loaded_o = |even_strb;
    assign odd_loaded_o  = |odd_strb;

endmodule

`default_nettype wire

// File: hdl/ibuf_invalidate.sv
`default_nettype none

module ibuf_invalidate
    import ibuf_ctrl_pkg::*;
(
    input  logic                 cf_i,
    input  bip_t                 new_bip_i,
    input  bip_t                 old_bip_i,
    input  slot_idx_t            even_slot_i,
    input  slot_idx_t            odd_slot_i,
    input  logic                 miss_even_i,
    input  logic                 miss_odd_i,
    output logic [NUM_SLOTS-1:0] inv_slot_o
);

    line_off_t            new_off;
    line_off_t            old_off;
    logic                 crossed;
    logic [NUM_SLOTS-1:0] cross_inv;
    logic [NUM_SLOTS-1:0] raw_inv;
    logic [NUM_SLOTS-1:0] hit_even;
    logic [NUM_SLOTS-1:0] hit_odd;

    assign new_off = bip_off(new_bip_i);
    assign old_off = bip_off(old_bip_i);

    // offset went backwards, so decode moved on to the next line
    assign crossed   = (new_off < old_off);
    assign cross_inv = crossed ? slot_onehot(bip_slot(old_bip_i)) : '0;

    assign raw_inv = cf_i ? {NUM_SLOTS{1'b1}} : cross_inv;

    // slots being filled by a hit this cycle keep their new line
    assign hit_even = miss_even_i ? '0 : (slot_onehot(even_slot_i) & EVEN_MASK);
    assign hit_odd  = miss_odd_i ? '0 : (slot_onehot(odd_slot_i) & ODD_MASK);

    assign inv_slot_o = raw_inv & ~(hit_even | hit_odd);

endmodule

`default_nettype wire

// File: hdl/ibuf_line_store.sv
`default_nettype none

module ibuf_line_store
    import ibuf_line_pkg::*;
    import ibuf_ctrl_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset_i,
    input  cache_line_t          line_even_i,
    input  cache_line_t          line_odd_i,
    input  logic [NUM_SLOTS-1:0] ld_slot_i,
    input  logic [NUM_SLOTS-1:0] inv_slot_i,
    output cache_line_t          line_00_o,
    output cache_line_t          line_01_o,
    output cache_line_t          line_10_o,
    output cache_line_t          line_11_o,
    output logic [NUM_SLOTS-1:0] valid_o
);

    cache_line_t          line_q [NUM_SLOTS];
    logic [NUM_SLOTS-1:0] valid_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int s = 0; s < NUM_SLOTS; s++) begin
                line_q[s] <= '0;
            end
            valid_q <= '0;
        end else begin
            for (int s = 0; s < NUM_SLOTS; s++) begin
                if (ld_slot_i[s]) begin
                    // odd slots are fed from the odd bank
                    line_q[s]  <= s[0] ? line_odd_i : line_even_i;
                    valid_q[s] <= 1'b1;
                end else if (inv_slot_i[s]) begin
                    valid_q[s] <= 1'b0; // data stays, only valid drops
                end
            end
        end
    end

    assign line_00_o = line_q[0];
    assign line_01_o = line_q[1];
    assign line_10_o = line_q[2];
    assign line_11_o = line_q[3];
    assign valid_o   = valid_q;

endmodule

`default_nettype wire

// File: hdl/ibuf_latch.sv
`default_nettype none

module ibuf_latch
    import ibuf_line_pkg::*;
    import ibuf_ctrl_pkg::*;
(
    input  logic        clk,
    input  logic        reset_i,
    input  logic        init_i,
    input  logic        resteer_i,
    input  logic        br_taken_i,
    input  cache_line_t line_even_i,
    input  cache_line_t line_odd_i,
    input  slot_idx_t   even_slot_i,
    input  slot_idx_t   odd_slot_i,
    input  logic        miss_even_i,
    input  logic        miss_odd_i,
    input  logic        wait_even_i,
    input  logic        wait_odd_i,
    input  bip_t        new_bip_i,
    input  bip_t        old_bip_i,
    output cache_line_t line_00_o,
    output cache_line_t line_01_o,
    output cache_line_t line_10_o,
    output cache_line_t line_11_o,
    output logic        line_00_valid_o,
    output logic        line_01_valid_o,
    output logic        line_10_valid_o,
    output logic        line_11_valid_o,
    output logic        even_loaded_o,
    output logic        odd_loaded_o
);

    logic                 cf;
    logic [NUM_SLOTS-1:0] ld_slot;
    logic [NUM_SLOTS-1:0] inv_slot;
    logic [NUM_SLOTS-1:0] valid;

    assign cf = init_i | resteer_i | br_taken_i; // any control flow change

    ibuf_fill_ctrl u_fill (
        .clk           (clk),
        .reset_i       (reset_i),
        .cf_i          (cf),
        .valid_i       (valid),
        .even_slot_i   (even_slot_i),
        .odd_slot_i    (odd_slot_i),
        .miss_even_i   (miss_even_i),
        .miss_odd_i    (miss_odd_i),
        .wait_even_i   (wait_even_i),
        .wait_odd_i    (wait_odd_i),
        .ld_slot_o     (ld_slot),
        .even_loaded_o (even_loaded_o),
        .odd_loaded_o  (odd_loaded_o)
    );

    ibuf_invalidate u_inv (
        .cf_i        (cf),
        .new_bip_i   (new_bip_i),
        .old_bip_i   (old_bip_i),
        .even_slot_i (even_slot_i),
        .odd_slot_i  (odd_slot_i),
        .miss_even_i (miss_even_i),
        .miss_odd_i  (miss_odd_i),
        .inv_slot_o  (inv_slot)
    );

    ibuf_line_store u_store (
        .clk         (clk),
        .reset_i     (reset_i),
        .line_even_i (line_even_i),
        .line_odd_i  (line_odd_i),
        .ld_slot_i   (ld_slot),
        .inv_slot_i  (inv_slot),
        .line_00_o   (line_00_o),
        .line_01_o   (line_01_o),
        .line_10_o   (line_10_o),
        .line_11_o   (line_11_o),
        .valid_o     (valid)
    );

    assign line_00_valid_o = valid[0];
    assign line_01_valid_o = valid[1];
    assign line_10_valid_o = valid[2];
    assign line_11_valid_o = valid[3];

endmodule

`default_nettype wire

// File: dv/ibuf_latch_assert.sv
`default_nettype none

module ibuf_latch_assert
    import ibuf_ctrl_pkg::*;
(
    input logic                 clk,
    input logic                 reset_i,
    input slot_idx_t            even_slot_i,
    input slot_idx_t            odd_slot_i,
    input logic                 miss_even_i,
    input logic                 even_loaded_i,
    input logic [NUM_SLOTS-1:0] ld_slot_i,
    input logic [NUM_SLOTS-1:0] valid_i
);

    a_slot_parity: assert property (@(posedge clk) disable iff (reset_i)
        !even_slot_i[0] && odd_slot_i[0])
        else $error("bank slot index has the wrong parity");

    a_no_even_on_miss: assert property (@(posedge clk) disable iff (reset_i)
        miss_even_i |-> !even_loaded_i)
        else $error("even bank loaded during a miss");

    // every strobed slot shows valid one cycle later
    a_load_sets_valid: assert property (@(posedge clk) disable iff (reset_i)
        |ld_slot_i |=> ((valid_i & $past(ld_slot_i)) == $past(ld_slot_i)))
        else $error("loaded slot not valid in the next cycle");

endmodule

bind ibuf_latch ibuf_latch_assert u_assert (
    .clk           (clk),
    .reset_i       (reset_i),
    .even_slot_i   (even_slot_i),
    .odd_slot_i    (odd_slot_i),
    .miss_even_i   (miss_even_i),
    .even_loaded_i (even_loaded_o),
    .ld_slot_i     (ld_slot),
    .valid_i       (valid)
);

`default_nettype wire

// File: dv/ibuf_latch_tb.sv
`default_nettype none

module ibuf_latch_tb
    import ibuf_line_pkg::*;
    import ibuf_ctrl_pkg::*;
();

    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYCLES = 8;
    localparam int TEST_CYCLES  = 40; // upper bound on cycles driven by the tests

    logic        clk;
    logic        reset_i;
    logic        init_i, resteer_i, br_taken_i;
    cache_line_t line_even_i, line_odd_i;
    slot_idx_t   even_slot_i, odd_slot_i;
    logic        miss_even_i, miss_odd_i, wait_even_i, wait_odd_i;
    bip_t        new_bip_i, old_bip_i;
    cache_line_t line_00_o, line_01_o, line_10_o, line_11_o;
    logic        line_00_valid_o, line_01_valid_o, line_10_valid_o, line_11_valid_o;
    logic        even_loaded_o, odd_loaded_o;

    // reference model of the four slots and the fill mode
    cache_line_t          exp_line [NUM_SLOTS];
    logic [NUM_SLOTS-1:0] exp_valid;
    ld_mode_t             exp_mode;

    logic [15:0] lfsr_q;
    int          check_cnt;
    int          err_cnt;

    ibuf_latch UUT (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    initial begin
        #((RESET_CYCLES + TEST_CYCLES) * CLK_PERIOD * 2);
        $display("timeout: the test sequence did not complete in time");
        $display("*** FAILED ***");
        $finish;
    end

    task automatic check_line(input string what, input cache_line_t got, input cache_line_t exp);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("MISMATCH @%0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_valid(input string what, input logic [NUM_SLOTS-1:0] got,
                               input logic [NUM_SLOTS-1:0] exp);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("MISMATCH @%0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("MISMATCH @%0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    // galois lfsr stepped once per bit taken
    function automatic cache_line_t rand_line();
        cache_line_t l;
        for (int b = 0; b < LINE_BITS; b++) begin
            l[b]   = lfsr_q[0];
            lfsr_q = lfsr_q >> 1;
            if (l[b]) begin
                lfsr_q = lfsr_q ^ 16'hB400;
            end
        end
        return l;
    endfunction

    function automatic ld_mode_t predict_mode(input logic [NUM_SLOTS-1:0] v);
        logic [NUM_SLOTS-1:0] e;
        e = ~v;
        if ((e[0] && e[1]) || (e[1] && e[2]) || (e[2] && e[3]) || (e[3] && e[0])) begin
            return LD_BOTH;
        end
        if (e[0] || e[2]) begin
            return LD_EVEN;
        end
        if (e[1] || e[3]) begin
            return LD_ODD;
        end
        return LD_NONE;
    endfunction

    function automatic logic [NUM_SLOTS-1:0] dut_valid();
        return {line_11_valid_o, line_10_valid_o, line_01_valid_o, line_00_valid_o};
    endfunction

    function automatic cache_line_t dut_line(input int s);
        case (s)
            0:       return line_00_o;
            1:       return line_01_o;
            2:       return line_10_o;
            default: return line_11_o;
        endcase
    endfunction

    task automatic set_idle();
        init_i      = 1'b0;
        resteer_i   = 1'b0;
        br_taken_i  = 1'b0;
        miss_even_i = 1'b0;
        miss_odd_i  = 1'b0;
        wait_even_i = 1'b0;
        wait_odd_i  = 1'b0;
        even_slot_i = 2'b00;
        odd_slot_i  = 2'b01;
        new_bip_i   = 6'h00;
        old_bip_i   = 6'h00;
        line_even_i = rand_line();
        line_odd_i  = rand_line();
    endtask

    // one clock with the inputs already driven and the model stepped alongside
    task automatic apply_cycle();
        logic                 cf;
        ld_mode_t             eff;
        logic                 take_even;
        logic                 take_odd;
        logic [NUM_SLOTS-1:0] ld;
        logic [NUM_SLOTS-1:0] inv;
        ld_mode_t             mode_next;
        cf        = init_i | resteer_i | br_taken_i;
        eff       = cf ? LD_BOTH : exp_mode;
        take_even = (eff == LD_EVEN || eff == LD_BOTH) && !miss_even_i && !wait_even_i
                    && !even_slot_i[0];
        take_odd  = (eff == LD_ODD || eff == LD_BOTH) && !miss_odd_i && !wait_odd_i
                    && odd_slot_i[0];
        ld = '0;
        if (take_even) begin
            ld[even_slot_i] = 1'b1;
        end
        if (take_odd) begin
            ld[odd_slot_i] = 1'b1;
        end
        inv = '0;
        if (cf) begin
            inv = '1;
        end else if (new_bip_i[3:0] < old_bip_i[3:0]) begin
            inv[old_bip_i[5:4]] = 1'b1; // decode left the old line
        end
        if (!miss_even_i && !even_slot_i[0]) begin
            inv[even_slot_i] = 1'b0;
        end
        if (!miss_odd_i && odd_slot_i[0]) begin
            inv[odd_slot_i] = 1'b0;
        end
        mode_next = predict_mode(exp_valid);
        @(negedge clk);
        check_flag("even_loaded_o", even_loaded_o, take_even);
        check_flag("odd_loaded_o", odd_loaded_o, take_odd);
        @(posedge clk);
        for (int s = 0; s < NUM_SLOTS; s++) begin
            if (ld[s]) begin
                exp_line[s]  = (s % 2 == 1) ? line_odd_i : line_even_i;
                exp_valid[s] = 1'b1;
            end else if (inv[s]) begin
                exp_valid[s] = 1'b0;
            end
        end
        if (!miss_even_i && !miss_odd_i) begin
            exp_mode = mode_next;
        end
        #1;
        check_valid("valid bits", dut_valid(), exp_valid);
        for (int s = 0; s < NUM_SLOTS; s++) begin
            check_line($sformatf("line slot %0d", s), dut_line(s), exp_line[s]);
        end
    endtask

    task automatic first_fill();
        check_valid("valid after reset", dut_valid(), 4'b0000);
        set_idle();
        apply_cycle();
        check_valid("valid after first fill", dut_valid(), 4'b0011);
    endtask

    task automatic bank_stall();
        set_idle();
        miss_even_i = 1'b1;
        apply_cycle(); // only odd slot 01 reloads
        set_idle();
        wait_odd_i = 1'b1;
        apply_cycle(); // only even slot 00 reloads
        set_idle();
        even_slot_i = 2'b10;
        odd_slot_i  = 2'b11;
        wait_even_i = 1'b1;
        apply_cycle();
        set_idle();
        even_slot_i = 2'b10;
        miss_odd_i  = 1'b1; // mode register holds LD_BOTH
        apply_cycle();
        set_idle();
        apply_cycle();
        check_valid("valid after stalls", dut_valid(), 4'b1111);
    endtask

    task automatic mode_follow();
        set_idle();
        old_bip_i = {2'b11, 4'hC};
        new_bip_i = {2'b00, 4'h2};
        apply_cycle();
        check_valid("slot 11 dropped", dut_valid(), 4'b0111);
        set_idle();
        apply_cycle();
        set_idle();
        even_slot_i = 2'b10;
        odd_slot_i  = 2'b11;
        apply_cycle(); // LD_ODD, only the odd bank fills
        set_idle();
        apply_cycle();
        set_idle();
        apply_cycle(); // full ring, nothing loads
    endtask

    task automatic pointer_wrap();
        set_idle();
        old_bip_i = {2'b01, 4'h8};
        new_bip_i = {2'b01, 4'hA};
        apply_cycle();
        set_idle();
        odd_slot_i = 2'b11;
        old_bip_i  = {2'b01, 4'hF};
        new_bip_i  = {2'b10, 4'h3};
        apply_cycle();
        check_valid("valid after wrap", dut_valid(), 4'b1101);
    endtask

    task automatic cf_event(input int which, input logic odd_miss);
        set_idle();
        init_i     = (which == 0);
        resteer_i  = (which == 1);
        br_taken_i = (which == 2);
        miss_odd_i = odd_miss;
        apply_cycle();
        check_valid("valid after redirect", dut_valid(), odd_miss ? 4'b0001 : 4'b0011);
        set_idle();
        apply_cycle();
    endtask

    initial begin
        clk       = 1'b0;
        reset_i   = 1'b1;
        lfsr_q    = 16'd27087;
        check_cnt = 0;
        err_cnt   = 0;
        set_idle();
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset_i   = 1'b0;
        exp_valid = '0;
        exp_mode  = LD_BOTH;
        for (int s = 0; s < NUM_SLOTS; s++) begin
            exp_line[s] = '0;
        end
        first_fill();
        bank_stall();
        mode_follow();
        pointer_wrap();
        cf_event(0, 1'b0);
        cf_event(1, 1'b0);
        cf_event(2, 1'b1);
        $display("checks: %0d  mismatches: %0d", check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
hdl/ibuf_line_pkg.sv
hdl/ibuf_ctrl_pkg.sv
hdl/ibuf_fill_ctrl.sv
hdl/ibuf_invalidate.sv
hdl/ibuf_line_store.sv
hdl/ibuf_latch.sv
dv/ibuf_latch_assert.sv
dv/ibuf_latch_tb.sv

// File: Makefile
VERILATOR  ?= verilator
FILELIST   := vlog.f
TOP        := ibuf_latch_tb
VFLAGS     := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing --assert -Wall
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := *** PASSED ***

SRCS := $(shell cat $(FILELIST))

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qF '$(PASS_MSG)' $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
